// ==== flist.f ====
output_writer_pkg.sv
stream_writer.sv
rr_arbiter.sv
output_writer.sv
tb_clock_gen.sv
output_writer_sva.sv
output_writer_tb.sv

// ==== output_writer.sv ====
`default_nettype none

module output_writer (
  input  logic clk,
  input  logic reset,

  // Normalized input streams
  input  logic [output_writer_pkg::DATA_W-1:0] data_in_data  [output_writer_pkg::NUM_STREAMS],
  input  logic [output_writer_pkg::KEEP_W-1:0] data_in_keep  [output_writer_pkg::NUM_STREAMS],
  input  logic                                 data_in_last  [output_writer_pkg::NUM_STREAMS],
  input  logic                                 data_in_valid [output_writer_pkg::NUM_STREAMS],
  output logic                                 data_in_ready [output_writer_pkg::NUM_STREAMS],

  // Host-bound output streams
  output logic [output_writer_pkg::DATA_W-1:0] data_out_data  [output_writer_pkg::NUM_STREAMS],
  output logic [output_writer_pkg::KEEP_W-1:0] data_out_keep  [output_writer_pkg::NUM_STREAMS],
  output logic                                 data_out_last  [output_writer_pkg::NUM_STREAMS],
  output logic                                 data_out_valid [output_writer_pkg::NUM_STREAMS],
  input  logic                                 data_out_ready [output_writer_pkg::NUM_STREAMS],

  // Per-stream host buffer base
  input  logic [output_writer_pkg::ADDR_W-1:0] base_addr [output_writer_pkg::NUM_STREAMS],

  // Write requests
  output logic [output_writer_pkg::REQ_W-1:0] req_data,
  output logic                                req_valid,
  input  logic                                req_ready,

  // Completions
  input  output_writer_pkg::cpl_word_u cpl_data,
  input  logic                         cpl_valid,
  output logic                         cpl_ready,

  // Packet notifications
  output logic [output_writer_pkg::NOTIFY_W-1:0] notify_data,
  output logic                                   notify_valid,
  input  logic                                   notify_ready
);

  // Writer side of the request arbiter
  logic [output_writer_pkg::REQ_W-1:0] wr_req_word  [output_writer_pkg::NUM_STREAMS];
  logic                                wr_req_valid [output_writer_pkg::NUM_STREAMS];
  logic                                wr_req_ready [output_writer_pkg::NUM_STREAMS];

  // Writer side of the notification arbiter
  logic [output_writer_pkg::NOTIFY_W-1:0] wr_notify_word  [output_writer_pkg::NUM_STREAMS];
  logic                                   wr_notify_valid [output_writer_pkg::NUM_STREAMS];
  logic                                   wr_notify_ready [output_writer_pkg::NUM_STREAMS];

  // Routed completion handshake
  logic                                      wr_cpl_valid [output_writer_pkg::NUM_STREAMS];
  logic                                      wr_cpl_ready [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::STREAM_ID_W-1:0] cpl_sel;

  // Stream id decode, same bits in ack and err words
  assign cpl_sel   = cpl_data.ack.stream;
  assign cpl_ready = wr_cpl_ready[cpl_sel];

  for (genvar i = 0; i < output_writer_pkg::NUM_STREAMS; i++) begin : g_stream
    // Valid only toward the addressed writer
    assign wr_cpl_valid[i] = cpl_valid && (int'(cpl_sel) == i);

    stream_writer #(
      .STREAM_ID(i)
    ) stream_writer_inst (
      .clk          (clk),
      .reset        (reset),
      .in_data      (data_in_data[i]),
      .in_keep      (data_in_keep[i]),
      .in_last      (data_in_last[i]),
      .in_valid     (data_in_valid[i]),
      .in_ready     (data_in_ready[i]),
      .out_data     (data_out_data[i]),
      .out_keep     (data_out_keep[i]),
      .out_last     (data_out_last[i]),
      .out_valid    (data_out_valid[i]),
      .out_ready    (data_out_ready[i]),
      .base_addr    (base_addr[i]),
      .req_word     (wr_req_word[i]),
      .req_valid    (wr_req_valid[i]),
      .req_ready    (wr_req_ready[i]),
      .cpl_word     (cpl_data),
      .cpl_valid    (wr_cpl_valid[i]),
      .cpl_ready    (wr_cpl_ready[i]),
      .notify_word  (wr_notify_word[i]),
      .notify_valid (wr_notify_valid[i]),
      .notify_ready (wr_notify_ready[i])
    );
  end

  // Requests from all streams onto one channel
  rr_arbiter #(
    .WIDTH(output_writer_pkg::REQ_W)
  ) req_arbiter_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (wr_req_word),
    .in_valid  (wr_req_valid),
    .in_ready  (wr_req_ready),
    .out_data  (req_data),
    .out_valid (req_valid),
    .out_ready (req_ready)
  );

  // Notifications from all streams onto one channel
  rr_arbiter #(
    .WIDTH(output_writer_pkg::NOTIFY_W)
  ) notify_arbiter_inst (
    .clk       (clk),
    .reset     (reset),
    .in_data   (wr_notify_word),
    .in_valid  (wr_notify_valid),
    .in_ready  (wr_notify_ready),
    .out_data  (notify_data),
    .out_valid (notify_valid),
    .out_ready (notify_ready)
  );

endmodule

`default_nettype wire

// ==== output_writer_pkg.sv ====
`default_nettype none

package output_writer_pkg;

  // Stream count and stream index width
  localparam int NUM_STREAMS = 2;
  localparam int STREAM_ID_W = 1;

  // Data beat, one keep bit per byte
  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;

  // Host address and byte length widths
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 16;

  // Full write transfer
  localparam int TRANSFER_BEATS = 4;
  localparam int TRANSFER_BYTES = TRANSFER_BEATS * KEEP_W;
  localparam int BEAT_CNT_W     = $clog2(TRANSFER_BEATS);

  // Unacknowledged requests per stream
  localparam int MAX_OUTSTANDING = 2;
  localparam int OUT_PTR_W       = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int OUT_CNT_W       = $clog2(MAX_OUTSTANDING + 1);

  // Request word, MSB first: stream id, address, length, last
  localparam int REQ_W = STREAM_ID_W + ADDR_W + LEN_W + 1;

  // Notification word, MSB first: stream id, error, packet bytes
  localparam int NOTIFY_W = STREAM_ID_W + 1 + LEN_W;

  // Completion word and the part behind kind and stream id
  localparam int CPL_W         = 20;
  localparam int CPL_PAYLOAD_W = CPL_W - 1 - STREAM_ID_W;

  // Completion kinds
  localparam logic CPL_KIND_ACK = 1'b0;
  localparam logic CPL_KIND_ERR = 1'b1;

  // Kind and stream id sit at the same bits in both views
  typedef union packed {
    struct packed {
      logic                     kind;
      logic [STREAM_ID_W-1:0]   stream;
      logic [CPL_PAYLOAD_W-1:0] seq;
    } ack;
    struct packed {
      logic                     kind;
      logic [STREAM_ID_W-1:0]   stream;
      logic [CPL_PAYLOAD_W-1:0] code;
    } err;
  } cpl_word_u;

endpackage

`default_nettype wire

// ==== output_writer_sva.sv ====
`default_nettype none

module output_writer_sva (
  input logic                                   clk,
  input logic                                   reset,
  input logic [output_writer_pkg::KEEP_W-1:0]   data_in_keep  [output_writer_pkg::NUM_STREAMS],
  input logic                                   data_in_last  [output_writer_pkg::NUM_STREAMS],
  input logic                                   data_in_valid [output_writer_pkg::NUM_STREAMS],
  input logic [output_writer_pkg::REQ_W-1:0]    req_data,
  input logic                                   req_valid,
  input logic                                   req_ready,
  input logic [output_writer_pkg::NOTIFY_W-1:0] notify_data,
  input logic                                   notify_valid,
  input logic                                   notify_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read back by the testbench
  int fail_count = 0;

  for (genvar i = 0; i < output_writer_pkg::NUM_STREAMS; i++) begin : g_keep
    // Inner beats carry all bytes
    keep_full_a : assert property (@(posedge clk) disable iff (reset)
      data_in_valid[i] && !data_in_last[i] |-> data_in_keep[i] == '1)
      else begin
        fail_count++;
        $error("keep not full on inner beat of stream %0d", i);
      end

    // Last beat keeps a nonzero run from byte 0
    keep_last_a : assert property (@(posedge clk) disable iff (reset)
      data_in_valid[i] && data_in_last[i] |->
        (data_in_keep[i] != '0) && ((data_in_keep[i] & (data_in_keep[i] + 1'b1)) == '0))
      else begin
        fail_count++;
        $error("bad keep on last beat of stream %0d", i);
      end
  end

  // Held word on the request channel
  req_hold_a : assert property (@(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req_data))
    else begin
      fail_count++;
      $error("request changed while stalled");
    end

  notify_hold_a : assert property (@(posedge clk) disable iff (reset)
    notify_valid && !notify_ready |=> notify_valid && $stable(notify_data))
    else begin
      fail_count++;
      $error("notification changed while stalled");
    end

endmodule

bind output_writer output_writer_sva output_writer_sva_inst (
  .clk          (clk),
  .reset        (reset),
  .data_in_keep (data_in_keep),
  .data_in_last (data_in_last),
  .data_in_valid(data_in_valid),
  .req_data     (req_data),
  .req_valid    (req_valid),
  .req_ready    (req_ready),
  .notify_data  (notify_data),
  .notify_valid (notify_valid),
  .notify_ready (notify_ready)
);

`default_nettype wire

// ==== output_writer_tb.sv ====
`default_nettype none

module output_writer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic reset;

  // DUT ports
  logic [output_writer_pkg::DATA_W-1:0]   data_in_data   [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::KEEP_W-1:0]   data_in_keep   [output_writer_pkg::NUM_STREAMS];
  logic                                   data_in_last   [output_writer_pkg::NUM_STREAMS];
  logic                                   data_in_valid  [output_writer_pkg::NUM_STREAMS];
  logic                                   data_in_ready  [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::DATA_W-1:0]   data_out_data  [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::KEEP_W-1:0]   data_out_keep  [output_writer_pkg::NUM_STREAMS];
  logic                                   data_out_last  [output_writer_pkg::NUM_STREAMS];
  logic                                   data_out_valid [output_writer_pkg::NUM_STREAMS];
  logic                                   data_out_ready [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::ADDR_W-1:0]   base_addr      [output_writer_pkg::NUM_STREAMS];
  logic [output_writer_pkg::REQ_W-1:0]    req_data;
  logic                                   req_valid;
  logic                                   req_ready;
  output_writer_pkg::cpl_word_u           cpl_data;
  logic                                   cpl_valid;
  logic                                   cpl_ready;
  logic [output_writer_pkg::NOTIFY_W-1:0] notify_data;
  logic                                   notify_valid;
  logic                                   notify_ready;

  // Packets per stream from the vector file
  int                                   pkt_beats [output_writer_pkg::NUM_STREAMS][$];
  logic [output_writer_pkg::KEEP_W-1:0] pkt_keep  [output_writer_pkg::NUM_STREAMS][$];
  logic [output_writer_pkg::ADDR_W-1:0] pkt_base  [output_writer_pkg::NUM_STREAMS][$];
  bit                                   pkt_err   [output_writer_pkg::NUM_STREAMS][$];

  // Expected results per stream
  logic [output_writer_pkg::DATA_W-1:0]   exp_data   [output_writer_pkg::NUM_STREAMS][$];
  logic [output_writer_pkg::KEEP_W-1:0]   exp_keep   [output_writer_pkg::NUM_STREAMS][$];
  logic                                   exp_last   [output_writer_pkg::NUM_STREAMS][$];
  logic [output_writer_pkg::REQ_W-1:0]    exp_req    [output_writer_pkg::NUM_STREAMS][$];
  logic [output_writer_pkg::NOTIFY_W-1:0] exp_notify [output_writer_pkg::NUM_STREAMS][$];

  // Host model state with an err flag per accepted request
  bit cpl_pend    [output_writer_pkg::NUM_STREAMS][$];
  int req_pkt     [output_writer_pkg::NUM_STREAMS];
  bit req_first   [output_writer_pkg::NUM_STREAMS];
  int outstanding [output_writer_pkg::NUM_STREAMS];
  int cpl_seq     [output_writer_pkg::NUM_STREAMS];
  bit drive_done  [output_writer_pkg::NUM_STREAMS];

  int vector_lines   = 0;
  bit vectors_loaded = 1'b0;

  tb_clock_gen tb_clock_gen_inst (
    .clk  (clk),
    .reset(reset)
  );

  output_writer output_writer_inst (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_data(
    input int s,
    input logic [output_writer_pkg::DATA_W-1:0] exp_d, act_d,
    input logic [output_writer_pkg::KEEP_W-1:0] exp_k, act_k,
    input logic exp_l, act_l
  );
    if (act_d !== exp_d)
      report_failure($sformatf("FAILED at %0t: data_out_data[%0d] expected %h got %h",
                               $time, s, exp_d, act_d));
    if (act_k !== exp_k)
      report_failure($sformatf("FAILED at %0t: data_out_keep[%0d] expected %h got %h",
                               $time, s, exp_k, act_k));
    if (act_l !== exp_l)
      report_failure($sformatf("FAILED at %0t: data_out_last[%0d] expected %b got %b",
                               $time, s, exp_l, act_l));
  endtask

  task automatic check_request(input logic [output_writer_pkg::REQ_W-1:0] exp_w, act_w);
    if (act_w !== exp_w)
      report_failure($sformatf("FAILED at %0t: req_data expected %h got %h",
                               $time, exp_w, act_w));
  endtask

  task automatic check_notify(input logic [output_writer_pkg::NOTIFY_W-1:0] exp_w, act_w);
    if (act_w !== exp_w)
      report_failure($sformatf("FAILED at %0t: notify_data expected %h got %h",
                               $time, exp_w, act_w));
  endtask

  // Beat content from stream, packet and beat index
  function automatic logic [output_writer_pkg::DATA_W-1:0] beat_pattern(input int s, p, b);
    return {8'(s), 8'(p), 8'(b), 8'h5a, 32'((s + 1) * 32'h0101_0101 * (p * 8 + b + 1))};
  endfunction

  task automatic read_vectors();
    int   fd;
    int   n;
    int   s;
    int   beats;
    int   flag;
    int   pkt_idx [output_writer_pkg::NUM_STREAMS];
    logic [output_writer_pkg::KEEP_W-1:0] keep;
    logic [output_writer_pkg::ADDR_W-1:0] addr;
    logic [output_writer_pkg::LEN_W-1:0]  len;
    string line;
    fd = $fopen("output_writer_vectors.txt", "r");
    if (fd == 0)
      report_failure("Could not open output_writer_vectors.txt");
    foreach (pkt_idx[i]) pkt_idx[i] = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;
      vector_lines++;
      case (line[0])
        "P": begin
          n = $sscanf(line, "P %d %d %h %h %d", s, beats, keep, addr, flag);
          if (n != 5) report_failure({"Malformed packet line: ", line});
          pkt_beats[s].push_back(beats);
          pkt_keep[s].push_back(keep);
          pkt_base[s].push_back(addr);
          pkt_err[s].push_back(flag != 0);
          for (int b = 0; b < beats; b++) begin
            exp_data[s].push_back(beat_pattern(s, pkt_idx[s], b));
            exp_keep[s].push_back((b == beats - 1) ? keep : '1);
            exp_last[s].push_back(b == beats - 1);
          end
          pkt_idx[s]++;
        end
        "R": begin
          n = $sscanf(line, "R %d %h %h %d", s, addr, len, flag);
          if (n != 4) report_failure({"Malformed request line: ", line});
          exp_req[s].push_back({output_writer_pkg::STREAM_ID_W'(s), addr, len, 1'(flag)});
        end
        "N": begin
          n = $sscanf(line, "N %d %d %h", s, flag, len);
          if (n != 3) report_failure({"Malformed notification line: ", line});
          exp_notify[s].push_back({output_writer_pkg::STREAM_ID_W'(s), 1'(flag), len});
        end
        default: report_failure({"Unknown vector line: ", line});
      endcase
    end
    $fclose(fd);
  endtask

  // One stream's packets beat by beat
  task automatic drive_stream(input int s);
    for (int p = 0; p < pkt_beats[s].size(); p++) begin
      for (int b = 0; b < pkt_beats[s][p]; b++) begin
        @(posedge clk);
        #2;
        base_addr[s]     = pkt_base[s][p];
        data_in_data[s]  = beat_pattern(s, p, b);
        data_in_last[s]  = (b == pkt_beats[s][p] - 1);
        data_in_keep[s]  = data_in_last[s] ? pkt_keep[s][p] : '1;
        data_in_valid[s] = 1'b1;
        @(negedge clk);
        while (!data_in_ready[s]) @(negedge clk);
      end
    end
    @(posedge clk);
    #2;
    data_in_valid[s] = 1'b0;
    data_in_last[s]  = 1'b0;
    drive_done[s]    = 1'b1;
  endtask

  function automatic bit all_done();
    bit done;
    done = 1'b1;
    for (int s = 0; s < output_writer_pkg::NUM_STREAMS; s++) begin
      if (!drive_done[s] || exp_data[s].size() != 0 || exp_req[s].size() != 0 ||
          exp_notify[s].size() != 0 || cpl_pend[s].size() != 0)
        done = 1'b0;
    end
    return done;
  endfunction

  // Output beats against the driven ones
  task automatic monitor_data();
    for (int s = 0; s < output_writer_pkg::NUM_STREAMS; s++) begin
      if (data_out_valid[s] && data_out_ready[s]) begin
        if (exp_data[s].size() == 0)
          report_failure($sformatf("Unexpected output beat on stream %0d", s));
        check_data(s, exp_data[s][0], data_out_data[s], exp_keep[s][0], data_out_keep[s],
                   exp_last[s][0], data_out_last[s]);
        void'(exp_data[s].pop_front());
        void'(exp_keep[s].pop_front());
        void'(exp_last[s].pop_front());
      end
    end
  endtask

  // Requests and the err choice for the host model
  task automatic monitor_requests();
    int  s;
    bit  last;
    if (req_valid && req_ready) begin
      s    = int'(req_data[output_writer_pkg::REQ_W-1 -: output_writer_pkg::STREAM_ID_W]);
      last = req_data[0];
      if (exp_req[s].size() == 0)
        report_failure($sformatf("Unexpected request from stream %0d", s));
      check_request(exp_req[s].pop_front(), req_data);
      // Err goes to the first request of a packet
      cpl_pend[s].push_back(req_first[s] && pkt_err[s][req_pkt[s]]);
      req_first[s] = last;
      if (last) req_pkt[s]++;
      outstanding[s]++;
      if (outstanding[s] > output_writer_pkg::MAX_OUTSTANDING)
        report_failure($sformatf("Stream %0d has too many requests without completion", s));
    end
  endtask

  task automatic monitor_completions();
    int s;
    if (cpl_valid && cpl_ready) begin
      s = int'(cpl_data.ack.stream);
      outstanding[s]--;
    end
  endtask

  task automatic monitor_notifications();
    int s;
    if (notify_valid && notify_ready) begin
      s = int'(notify_data[output_writer_pkg::NOTIFY_W-1 -: output_writer_pkg::STREAM_ID_W]);
      if (exp_notify[s].size() == 0)
        report_failure($sformatf("Unexpected notification from stream %0d", s));
      check_notify(exp_notify[s].pop_front(), notify_data);
    end
  endtask

  // All sampling at the falling edge where everything is settled
  always @(negedge clk) begin
    if (reset === 1'b0 && vectors_loaded) begin
      monitor_data();
      monitor_requests();
      monitor_completions();
      monitor_notifications();
      if (output_writer_inst.output_writer_sva_inst.fail_count != 0)
        report_failure("A bound assertion on the DUT failed");
    end
  end

  // Random back-pressure once reset is seen low at the rising edge
  always begin
    @(posedge clk);
    if (reset === 1'b0) begin
      #2;
      foreach (data_out_ready[s]) data_out_ready[s] = ($urandom_range(0, 3) != 0);
      req_ready    = ($urandom_range(0, 3) != 0);
      notify_ready = ($urandom_range(0, 2) != 0);
    end
  end

  // Host model returns completions in order per stream after a random delay
  initial begin : host_model
    int s;
    int start;
    int n;
    bit found;
    wait (vectors_loaded && reset === 1'b0);
    forever begin
      @(posedge clk);
      #2;
      cpl_valid = 1'b0;
      found = 1'b0;
      start = $urandom_range(0, output_writer_pkg::NUM_STREAMS - 1);
      for (int k = 0; k < output_writer_pkg::NUM_STREAMS; k++) begin
        if (!found && cpl_pend[(start + k) % output_writer_pkg::NUM_STREAMS].size() != 0) begin
          found = 1'b1;
          s = (start + k) % output_writer_pkg::NUM_STREAMS;
        end
      end
      if (found) begin
        n = $urandom_range(0, 3);
        repeat (n) begin
          @(posedge clk);
          #2;
        end
        if (cpl_pend[s][0]) begin
          cpl_data.err.kind   = output_writer_pkg::CPL_KIND_ERR;
          cpl_data.err.stream = output_writer_pkg::STREAM_ID_W'(s);
          cpl_data.err.code   = output_writer_pkg::CPL_PAYLOAD_W'(1);
        end else begin
          cpl_data.ack.kind   = output_writer_pkg::CPL_KIND_ACK;
          cpl_data.ack.stream = output_writer_pkg::STREAM_ID_W'(s);
          cpl_data.ack.seq    = output_writer_pkg::CPL_PAYLOAD_W'(cpl_seq[s]);
        end
        cpl_valid = 1'b1;
        @(negedge clk);
        while (!cpl_ready) @(negedge clk);
        void'(cpl_pend[s].pop_front());
        cpl_seq[s]++;
      end
    end
  end

  // 200 cycles of 20 ns per vector line
  initial begin : watchdog
    wait (vectors_loaded);
    #(vector_lines * 4000);
    $display("Timeout: the DUT did not finish all vectors in time");
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin : main
    void'($urandom(78));
    foreach (data_in_valid[s]) begin
      data_in_data[s]   = '0;
      data_in_keep[s]   = '0;
      data_in_last[s]   = 1'b0;
      data_in_valid[s]  = 1'b0;
      data_out_ready[s] = 1'b0;
      base_addr[s]      = '0;
      req_pkt[s]        = 0;
      req_first[s]      = 1'b1;
      outstanding[s]    = 0;
      cpl_seq[s]        = 0;
      drive_done[s]     = 1'b0;
    end
    req_ready    = 1'b0;
    cpl_data     = '0;
    cpl_valid    = 1'b0;
    notify_ready = 1'b0;
    read_vectors();
    vectors_loaded = 1'b1;
    wait (reset === 1'b0);
    for (int s = 0; s < output_writer_pkg::NUM_STREAMS; s++) begin
      fork
        automatic int k = s;
        drive_stream(k);
      join_none
    end
    while (!all_done()) @(negedge clk);
    // Idle time to catch extra requests or notifications
    repeat (40) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== output_writer_vectors.txt ====
# P stream beats last_keep(hex) base_addr(hex) err_on_first | R stream addr(hex) len(hex) last
# N stream err bytes(hex)
P 0 5 0f 00001000 0
R 0 00001000 0020 0
R 0 00001020 0004 1
N 0 0 0024
P 1 3 3f 10000000 0
R 1 10000000 0016 1
N 1 0 0016
P 0 4 ff 00002000 0
R 0 00002000 0020 1
N 0 0 0020
P 1 8 ff 10000100 0
R 1 10000100 0020 0
R 1 10000120 0020 1
N 1 0 0040
P 0 9 07 00003000 1
R 0 00003000 0020 0
R 0 00003020 0020 0
R 0 00003040 0003 1
N 0 1 0000
P 1 6 1f 10000200 1
R 1 10000200 0020 0
R 1 10000220 000d 1
N 1 1 0000
P 0 2 01 00004000 0
R 0 00004000 0009 1
N 0 0 0009
P 1 1 ff 10000300 0
R 1 10000300 0008 1
N 1 0 0008

// ==== rr_arbiter.sv ====
`default_nettype none

module rr_arbiter #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] in_data  [output_writer_pkg::NUM_STREAMS],
  input  logic             in_valid [output_writer_pkg::NUM_STREAMS],
  output logic             in_ready [output_writer_pkg::NUM_STREAMS],
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [output_writer_pkg::STREAM_ID_W-1:0] last_grant;
  logic [output_writer_pkg::STREAM_ID_W-1:0] grant_idx;
  logic                                      grant_any;
  logic                                      load_en;

  // Output register empty or draining this cycle
  assign load_en = !out_valid || out_ready;

  // Search starts one past the last granted stream
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_idx = last_grant;
    for (int k = 1; k <= output_writer_pkg::NUM_STREAMS; k++) begin
      idx = int'(last_grant) + k;
      if (idx >= output_writer_pkg::NUM_STREAMS) begin
        idx = idx - output_writer_pkg::NUM_STREAMS;
      end
      if (!grant_any && in_valid[idx]) begin
        grant_any = 1'b1;
        grant_idx = output_writer_pkg::STREAM_ID_W'(idx);
      end
    end
  end

  // Ready only toward the granted requester
  always_comb begin
    for (int s = 0; s < output_writer_pkg::NUM_STREAMS; s++) begin
      in_ready[s] = load_en && grant_any &&
                    (grant_idx == output_writer_pkg::STREAM_ID_W'(s));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      // Stream 0 wins first after reset
      last_grant <= output_writer_pkg::STREAM_ID_W'(output_writer_pkg::NUM_STREAMS - 1);
    end else if (load_en) begin
      out_valid <= grant_any;
      if (grant_any) begin
        last_grant <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en && grant_any) begin
      out_data <= in_data[grant_idx];
    end
  end

endmodule

`default_nettype wire

// ==== stream_writer.sv ====
`default_nettype none

module stream_writer #(
  parameter int unsigned STREAM_ID = 0
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [output_writer_pkg::DATA_W-1:0] in_data,
  input  logic [output_writer_pkg::KEEP_W-1:0] in_keep,
  input  logic                                 in_last,
  input  logic                                 in_valid,
  output logic                                 in_ready,
  output logic [output_writer_pkg::DATA_W-1:0] out_data,
  output logic [output_writer_pkg::KEEP_W-1:0] out_keep,
  output logic                                 out_last,
  output logic                                 out_valid,
  input  logic                                 out_ready,
  input  logic [output_writer_pkg::ADDR_W-1:0] base_addr,
  output logic [output_writer_pkg::REQ_W-1:0]  req_word,
  output logic                                 req_valid,
  input  logic                                 req_ready,
  input  output_writer_pkg::cpl_word_u         cpl_word,
  input  logic                                 cpl_valid,
  output logic                                 cpl_ready,
  output logic [output_writer_pkg::NOTIFY_W-1:0] notify_word,
  output logic                                 notify_valid,
  input  logic                                 notify_ready
);

  // Transfer cutting
  logic [output_writer_pkg::BEAT_CNT_W-1:0] beat_cnt;
  logic [output_writer_pkg::LEN_W-1:0]      pkt_offset;
  logic [output_writer_pkg::LEN_W-1:0]      keep_bytes;
  logic [output_writer_pkg::LEN_W-1:0]      xfer_bytes;
  logic [output_writer_pkg::LEN_W-1:0]      pkt_bytes;
  logic                                     stall;
  logic                                     beat_fire;
  logic                                     xfer_close;
  logic                                     push;

  // In-order outstanding table
  logic                                    tbl_last  [output_writer_pkg::MAX_OUTSTANDING];
  logic [output_writer_pkg::LEN_W-1:0]     tbl_bytes [output_writer_pkg::MAX_OUTSTANDING];
  logic [output_writer_pkg::OUT_PTR_W-1:0] wr_ptr;
  logic [output_writer_pkg::OUT_PTR_W-1:0] rd_ptr;
  logic [output_writer_pkg::OUT_CNT_W-1:0] out_cnt;
  logic                                    head_last;
  logic [output_writer_pkg::LEN_W-1:0]     head_bytes;

  // Completion handling
  logic cpl_fire;
  logic cpl_is_err;
  logic drop_pkt;

  // Byte count of a keep word
  function automatic logic [output_writer_pkg::LEN_W-1:0] count_ones(
    input logic [output_writer_pkg::KEEP_W-1:0] keep
  );
    logic [output_writer_pkg::LEN_W-1:0] n;
    n = '0;
    for (int b = 0; b < output_writer_pkg::KEEP_W; b++) begin
      n = n + output_writer_pkg::LEN_W'(keep[b]);
    end
    return n;
  endfunction

  // Table pointer with wrap
  function automatic logic [output_writer_pkg::OUT_PTR_W-1:0] next_ptr(
    input logic [output_writer_pkg::OUT_PTR_W-1:0] ptr
  );
    if (ptr == output_writer_pkg::OUT_PTR_W'(output_writer_pkg::MAX_OUTSTANDING - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Hold data while a request waits or the table is full
  assign stall = req_valid ||
                 (out_cnt == output_writer_pkg::OUT_CNT_W'(output_writer_pkg::MAX_OUTSTANDING));

  // Combinational pass-through
  assign out_data  = in_data;
  assign out_keep  = in_keep;
  assign out_last  = in_last;
  assign out_valid = in_valid && !stall;
  assign in_ready  = out_ready && !stall;
  assign beat_fire = in_valid && in_ready;

  assign xfer_close = in_last ||
    (beat_cnt == output_writer_pkg::BEAT_CNT_W'(output_writer_pkg::TRANSFER_BEATS - 1));
  assign push       = beat_fire && xfer_close;
  assign keep_bytes = count_ones(in_keep);

  // Full beats before the closing one, plus its keep bytes
  always_comb begin
    if (in_last) begin
      xfer_bytes = output_writer_pkg::LEN_W'(beat_cnt) *
                   output_writer_pkg::LEN_W'(output_writer_pkg::KEEP_W) + keep_bytes;
    end else begin
      xfer_bytes = output_writer_pkg::LEN_W'(output_writer_pkg::TRANSFER_BYTES);
    end
  end

  assign pkt_bytes = pkt_offset + xfer_bytes;

  // Beat counter and packet offset
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt   <= '0;
      pkt_offset <= '0;
    end else if (beat_fire) begin
      if (xfer_close) begin
        beat_cnt   <= '0;
        // Next packet starts at base again
        pkt_offset <= in_last ? '0 : pkt_bytes;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Request register loads one cycle after the closing beat
  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else if (push) begin
      req_valid <= 1'b1;
    end else if (req_ready) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      req_word <= {output_writer_pkg::STREAM_ID_W'(STREAM_ID),
                   base_addr + output_writer_pkg::ADDR_W'(pkt_offset),
                   xfer_bytes,
                   in_last};
    end
  end

  // Entry holds last flag and packet bytes so far
  always_ff @(posedge clk) begin
    if (push) begin
      tbl_last[wr_ptr]  <= in_last;
      tbl_bytes[wr_ptr] <= pkt_bytes;
    end
  end

  assign head_last  = tbl_last[rd_ptr];
  assign head_bytes = tbl_bytes[rd_ptr];

  // Take a completion only if a pending notification can move on
  assign cpl_ready  = (out_cnt != '0) && (!notify_valid || notify_ready);
  assign cpl_fire   = cpl_valid && cpl_ready;
  assign cpl_is_err = (cpl_word.err.kind == output_writer_pkg::CPL_KIND_ERR);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      out_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (cpl_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, cpl_fire})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: out_cnt <= out_cnt;
      endcase
    end
  end

  // Notification valid and packet drop after an error
  always_ff @(posedge clk) begin
    if (reset) begin
      notify_valid <= 1'b0;
      drop_pkt     <= 1'b0;
    end else begin
      if (notify_valid && notify_ready) begin
        notify_valid <= 1'b0;
      end
      if (cpl_fire) begin
        if (drop_pkt) begin
          // Silent pops until the packet's last entry
          drop_pkt <= !head_last;
        end else if (cpl_is_err) begin
          notify_valid <= 1'b1;
          drop_pkt     <= !head_last;
        end else if (head_last) begin
          notify_valid <= 1'b1;
        end
      end
    end
  end

  // Error notifications report zero bytes
  always_ff @(posedge clk) begin
    if (cpl_fire && !drop_pkt && (cpl_is_err || head_last)) begin
      if (cpl_is_err) begin
        notify_word <= {output_writer_pkg::STREAM_ID_W'(STREAM_ID), 1'b1,
                        {output_writer_pkg::LEN_W{1'b0}}};
      end else begin
        notify_word <= {output_writer_pkg::STREAM_ID_W'(STREAM_ID), 1'b0, head_bytes};
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Reset held for 3 rising edges, released just after the third
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire
